// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := exec_unit_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line is in the log
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_bus_if.sv
rtl/exec_pipe_stage.sv
rtl/exec_decode.sv
rtl/exec_result.sv
rtl/exec_next_pc.sv
rtl/exec_commit.sv
rtl/exec_unit.sv
dv/exec_unit_asserts.sv
dv/exec_unit_tb.sv

// ==== dv/exec_unit_asserts.sv ====
`timescale 1ns/10ps

module exec_unit_asserts (
    input logic                clk,
    input logic                reset,
    input logic                in_valid,
    input logic                in_ready,
    input exec_pkg::opcode_t   in_opcode,
    input logic [2:0]          in_funct3,
    input exec_pkg::word_t     in_rs1_data,
    input exec_pkg::word_t     in_rs2_data,
    input exec_pkg::word_t     in_imm,
    input exec_pkg::word_t     in_pc,
    input exec_pkg::word_t     in_mem_data,
    input exec_pkg::reg_addr_t in_rd,
    input logic                in_reg_write_en,
    input logic                out_valid,
    input logic                out_ready,
    input exec_pkg::reg_addr_t out_rd,
    input logic                out_we,
    input exec_pkg::word_t     out_result,
    input exec_pkg::word_t     out_next_pc,
    input logic                out_trap
);

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid
            && $stable({out_rd, out_we, out_result, out_next_pc, out_trap}))
        else $error("output record changed while out_ready was low");

    // producer side of the same rule
    a_in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid
            && $stable({in_opcode, in_funct3, in_rs1_data, in_rs2_data, in_imm,
                        in_pc, in_mem_data, in_rd, in_reg_write_en}))
        else $error("input request changed while in_ready was low");

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_we |-> out_rd != 5'd0)
        else $error("write enabled for register x0");

    a_trap_no_write: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_trap |-> !out_we)
        else $error("write enabled on a trapped instruction");

endmodule

bind exec_unit exec_unit_asserts u_asserts (.*);

// ==== dv/exec_unit_tb.sv ====
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_unit_tb;
    import exec_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    typedef struct packed {
        opcode_t    opc;
        logic [2:0] f3;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        word_t      pc;
        word_t      mem;
        reg_addr_t  rd;
        logic       we;
    } vec_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    logic       in_ready;
    opcode_t    in_opcode;
    logic [2:0] in_funct3;
    word_t      in_rs1_data;
    word_t      in_rs2_data;
    word_t      in_imm;
    word_t      in_pc;
    word_t      in_mem_data;
    reg_addr_t  in_rd;
    logic       in_reg_write_en;
    logic       out_valid;
    logic       out_ready;
    reg_addr_t  out_rd;
    logic       out_we;
    word_t      out_result;
    word_t      out_next_pc;
    logic       out_trap;

    vec_t    vecs[$];
    string   names[$];
    commit_t expect_q[$];
    string   name_q[$];
    int      accept_q[$]; // cycle of each input transfer
    int      cycle = 0;
    int      out_count = 0;
    int      value_errors = 0;
    int      other_errors = 0;
    int      timeout_count = 0;
    logic    timed_out = 1'b0;
    logic    random_bp = 1'b0;
    logic    latency_mode = 1'b0;
    integer  seed = 32'h103f_75a8;

    exec_unit UUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // consumer stalls at random only while random_bp is set
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (reset || !random_bp) begin
                out_ready = 1'b1;
            end else begin
                out_ready = (($random(seed) & 32'd1) != 32'd0);
            end
        end
    end

    task automatic add_vec(input string name, input opcode_t opc, input logic [2:0] f3,
                           input word_t rs1, input word_t rs2, input word_t imm,
                           input word_t pc, input word_t mem, input reg_addr_t rd,
                           input logic we);
        vecs.push_back('{opc, f3, rs1, rs2, imm, pc, mem, rd, we});
        names.push_back(name);
    endtask

    function automatic commit_t expected_commit(input vec_t v);
        commit_t c;
        word_t   seq_pc;
        word_t   target;
        logic    illegal;
        logic    misaligned;
        logic    writes;
        seq_pc     = v.pc + 32'd4;
        target     = v.pc + v.imm;
        illegal    = 1'b0;
        misaligned = 1'b0;
        writes     = 1'b1;
        c.rd       = v.rd;
        c.result   = v.rs1 + v.imm;
        c.next_pc  = seq_pc;
        case (v.opc)
            OPC_OP_IMM: illegal = (v.f3 != 3'b000);
            OPC_LUI:    c.result = v.imm;
            OPC_AUIPC:  c.result = target;
            OPC_JAL: begin
                c.result   = seq_pc;
                c.next_pc  = target;
                misaligned = target[1];
            end
            OPC_JALR: begin
                illegal    = (v.f3 != 3'b000);
                c.result   = seq_pc;
                c.next_pc  = (v.rs1 + v.imm) & 32'hffff_fffe;
                misaligned = c.next_pc[1];
            end
            OPC_LOAD: begin
                illegal  = (v.f3 != 3'b010);
                c.result = v.mem;
            end
            OPC_BRANCH: begin
                illegal = (v.f3 != 3'b000);
                writes  = 1'b0;
                if (v.rs1 == v.rs2) begin
                    c.next_pc  = target;
                    misaligned = target[1];
                end
            end
            default: illegal = 1'b1;
        endcase
        c.trap = illegal || misaligned;
        c.we   = !c.trap && writes && v.we && (v.rd != 5'd0);
        if (c.trap) begin
            c.next_pc = `EXEC_TRAP_VEC;
        end
        return c;
    endfunction

    task automatic check_word(input string name, input string field,
                              input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %h, actual %h", name, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_reg(input string name, input string field,
                             input reg_addr_t expected, input reg_addr_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %b, actual %b", name, field, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_output();
        commit_t exp;
        string   name;
        int      latency;
        if (expect_q.size() == 0) begin
            $display("unexpected output record with rd %0d and result %h", out_rd, out_result);
            other_errors++;
        end else begin
            exp     = expect_q.pop_front();
            name    = name_q.pop_front();
            latency = cycle - accept_q.pop_front();
            check_reg(name, "rd", exp.rd, out_rd);
            check_flag(name, "we", exp.we, out_we);
            check_flag(name, "trap", exp.trap, out_trap);
            check_word(name, "next_pc", exp.next_pc, out_next_pc);
            if (!exp.trap) begin
                check_word(name, "result", exp.result, out_result);
            end
            if (latency_mode && latency != 2) begin
                $display("%s took %0d cycles to come out instead of 2", name, latency);
                other_errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            out_count++;
            check_output();
        end
    end

    task automatic send(input vec_t v, input string name);
        int waited;
        if (!timed_out) begin
            in_opcode       = v.opc;
            in_funct3       = v.f3;
            in_rs1_data     = v.rs1;
            in_rs2_data     = v.rs2;
            in_imm          = v.imm;
            in_pc           = v.pc;
            in_mem_data     = v.mem;
            in_rd           = v.rd;
            in_reg_write_en = v.we;
            in_valid        = 1'b1;
            expect_q.push_back(expected_commit(v));
            name_q.push_back(name);
            waited = 0;
            @(negedge clk);
            while (!in_ready && !timed_out) begin
                if (waited == TIMEOUT_CYCLES) begin
                    $display("timeout: %s was not accepted within %0d cycles",
                             name, TIMEOUT_CYCLES);
                    timeout_count++;
                    timed_out = 1'b1;
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
            accept_q.push_back(cycle);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0 && !timed_out) begin
            if (waited == TIMEOUT_CYCLES) begin
                $display("timeout: %0d results never came out", expect_q.size());
                timeout_count++;
                timed_out = 1'b1;
            end else begin
                waited++;
                @(posedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_opcode       = '0;
        in_funct3       = '0;
        in_rs1_data     = '0;
        in_rs2_data     = '0;
        in_imm          = '0;
        in_pc           = '0;
        in_mem_data     = '0;
        in_rd           = '0;
        in_reg_write_en = 1'b0;

        //      name                opcode      f3    rs1      rs2   imm          pc       mem
        add_vec("addi",             OPC_OP_IMM, 3'd0, 'h10,    'h0, 'h5,        'h1000,
                'h0, 5'd3, 1'b1);
        add_vec("addi_neg_imm",     OPC_OP_IMM, 3'd0, 'h100,   'h0, 'hffff_fff0, 'h1004,
                'h0, 5'd4, 1'b1);
        add_vec("lui",              OPC_LUI,    3'd5, 'hdead,  'h0, 'h1234_5000, 'h1008,
                'h0, 5'd5, 1'b1);
        add_vec("auipc",            OPC_AUIPC,  3'd0, 'h0,     'h0, 'h2000,     'h1008,
                'h0, 5'd6, 1'b1);
        add_vec("auipc_wrap",       OPC_AUIPC,  3'd0, 'h0,     'h0, 'h2000,     'hffff_f000,
                'h0, 5'd9, 1'b1);
        add_vec("lw",               OPC_LOAD,   3'd2, 'h40,    'h0, 'h8,        'h100c,
                'hcafe_f00d, 5'd7, 1'b1);
        add_vec("jal",              OPC_JAL,    3'd0, 'h0,     'h0, 'h40,       'h1010,
                'h0, 5'd1, 1'b1);
        add_vec("jalr",             OPC_JALR,   3'd0, 'h2000,  'h0, 'h10,       'h1014,
                'h0, 5'd1, 1'b1);
        add_vec("jalr_odd_target",  OPC_JALR,   3'd0, 'h2001,  'h0, 'h4,        'h1018,
                'h0, 5'd2, 1'b1);
        add_vec("beq_taken",        OPC_BRANCH, 3'd0, 'h7,     'h7, 'h20,       'h1020,
                'h0, 5'd5, 1'b1);
        add_vec("beq_not_taken",    OPC_BRANCH, 3'd0, 'h7,     'h8, 'h20,       'h1024,
                'h0, 5'd5, 1'b1);
        add_vec("beq_misal_untaken", OPC_BRANCH, 3'd0, 'h1,    'h2, 'h22,       'h1030,
                'h0, 5'd0, 1'b0);
        add_vec("beq_misal_taken",  OPC_BRANCH, 3'd0, 'h3,     'h3, 'h22,       'h1030,
                'h0, 5'd0, 1'b0);
        add_vec("jal_misaligned",   OPC_JAL,    3'd0, 'h0,     'h0, 'h42,       'h1000,
                'h0, 5'd1, 1'b1);
        add_vec("jalr_misaligned",  OPC_JALR,   3'd0, 'h3000,  'h0, 'h6,        'h1040,
                'h0, 5'd1, 1'b1);
        add_vec("bne_illegal",      OPC_BRANCH, 3'd1, 'h1,     'h2, 'h10,       'h1044,
                'h0, 5'd0, 1'b0);
        add_vec("store_illegal",    7'b0100011, 3'd2, 'h80,    'h5, 'h4,        'h1048,
                'h0, 5'd3, 1'b1);
        add_vec("xori_illegal",     OPC_OP_IMM, 3'd4, 'h10,    'h0, 'h5,        'h104c,
                'h0, 5'd3, 1'b1);
        add_vec("lb_illegal",       OPC_LOAD,   3'd0, 'h40,    'h0, 'h8,        'h1050,
                'h1234, 5'd7, 1'b1);
        add_vec("addi_rd0",         OPC_OP_IMM, 3'd0, 'h22,    'h0, 'h11,       'h1054,
                'h0, 5'd0, 1'b1);
        add_vec("addi_we_off",      OPC_OP_IMM, 3'd0, 'h22,    'h0, 'h11,       'h1058,
                'h0, 5'd8, 1'b0);
        add_vec("jal_rd0",          OPC_JAL,    3'd0, 'h0,     'h0, 'h100,      'h105c,
                'h0, 5'd0, 1'b1);

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_flag("reset", "out_valid", 1'b0, out_valid);
        check_flag("reset", "in_ready", 1'b1, in_ready);
        check_flag("reset", "out_we", 1'b0, out_we);
        check_flag("reset", "out_trap", 1'b0, out_trap);
        @(posedge clk);
        #1;

        random_bp = 1'b1; // pass 1 under random back-pressure
        foreach (vecs[i]) begin
            send(vecs[i], names[i]);
        end
        in_valid  = 1'b0;
        random_bp = 1'b0;
        drain();

        latency_mode = 1'b1; // pass 2 back to back without stalls
        foreach (vecs[i]) begin
            send(vecs[i], names[i]);
        end
        in_valid = 1'b0;
        drain();

        if (!timed_out && out_count != 2 * vecs.size()) begin
            $display("saw %0d output records but sent %0d", out_count, 2 * vecs.size());
            other_errors++;
        end
        $display("errors: %0d value, %0d other, %0d timeout",
                 value_errors, other_errors, timeout_count);
        if (value_errors == 0 && other_errors == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== rtl/exec_bus_if.sv ====
`timescale 1ns/10ps

interface exec_bus_if;
    import exec_pkg::*;

    logic      valid;
    logic      ready;
    exec_req_t req;
    word_t     result;
    word_t     next_pc;
    logic      target_misaligned;

    modport stage (
        output valid,
        output req,
        input  ready
    );

    modport result_unit (
        input  req,
        output result
    );

    modport pc_unit (
        input  req,
        output next_pc,
        output target_misaligned
    );

    modport commit (
        input  valid,
        input  req,
        input  result,
        input  next_pc,
        input  target_misaligned,
        output ready
    );

endinterface

// ==== rtl/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// pc taken on illegal encodings and misaligned targets
`define EXEC_TRAP_VEC 32'h0000_0100

// payload value of a stage after reset, sized by the payload type
`define EXEC_RESET_WORD '0

`endif

// ==== rtl/exec_commit.sv ====
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_commit (
    exec_bus_if.commit        bus,
    output logic              out_valid,
    input  logic              out_ready,
    output exec_pkg::commit_t out_data
);
    import exec_pkg::*;

    logic trap;
    logic class_writes;
    logic rd_nonzero;

    // handshake passes straight through to the output stage
    assign out_valid = bus.valid;
    assign bus.ready = out_ready;

    assign trap = (bus.req.op == OP_ILLEGAL) || bus.target_misaligned;

    always_comb begin
        case (bus.req.op)
            OP_ADDI,
            OP_LUI,
            OP_AUIPC,
            OP_JAL,
            OP_JALR,
            OP_LW:   class_writes = 1'b1;
            default: class_writes = 1'b0; // beq and illegal
        endcase
    end

    assign rd_nonzero = (bus.req.rd != '0); // x0 is never written

    assign out_data.rd      = bus.req.rd;
    assign out_data.we      = !trap && class_writes && bus.req.we && rd_nonzero;
    assign out_data.result  = bus.result;
    assign out_data.next_pc = trap ? `EXEC_TRAP_VEC : bus.next_pc;
    assign out_data.trap    = trap;

endmodule

// ==== rtl/exec_decode.sv ====
`timescale 1ns/10ps

module exec_decode (
    input  exec_pkg::opcode_t   opcode,
    input  logic [2:0]          funct3,
    input  exec_pkg::word_t     rs1_data,
    input  exec_pkg::word_t     rs2_data,
    input  exec_pkg::word_t     imm,
    input  exec_pkg::word_t     pc,
    input  exec_pkg::word_t     mem_data,
    input  exec_pkg::reg_addr_t rd,
    input  logic                reg_write_en,
    output exec_pkg::exec_req_t req
);
    import exec_pkg::*;

    op_class_e op;

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_LUI:   op = OP_LUI;   // funct3 is part of the immediate
            OPC_AUIPC: op = OP_AUIPC;
            OPC_JAL:   op = OP_JAL;
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op = OP_JALR;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    op = OP_LW;
                end
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    op = OP_BEQ;
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    assign req.op       = op;
    assign req.rs1_data = rs1_data;
    assign req.rs2_data = rs2_data;
    assign req.imm      = imm;
    assign req.pc       = pc;
    assign req.mem_data = mem_data;
    assign req.rd       = rd;
    assign req.we       = reg_write_en;

endmodule

// ==== rtl/exec_next_pc.sv ====
`timescale 1ns/10ps

module exec_next_pc (
    exec_bus_if.pc_unit bus
);
    import exec_pkg::*;

    word_t seq_pc;
    word_t jal_target;
    word_t jalr_target;
    logic  branch_taken;

    assign seq_pc       = bus.req.pc + 32'd4;
    assign jal_target   = bus.req.pc + bus.req.imm; // also the beq target
    assign jalr_target  = (bus.req.rs1_data + bus.req.imm) & ~32'h1;
    assign branch_taken = (bus.req.rs1_data == bus.req.rs2_data);

    always_comb begin
        bus.next_pc           = seq_pc;
        bus.target_misaligned = 1'b0;
        case (bus.req.op)
            OP_JAL: begin
                bus.next_pc           = jal_target;
                bus.target_misaligned = jal_target[1];
            end
            OP_JALR: begin
                bus.next_pc           = jalr_target;
                bus.target_misaligned = jalr_target[1];
            end
            OP_BEQ: begin
                // not-taken branch never faults
                if (branch_taken) begin
                    bus.next_pc           = jal_target;
                    bus.target_misaligned = jal_target[1];
                end
            end
            default: begin
                bus.next_pc           = seq_pc;
                bus.target_misaligned = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/exec_pipe_stage.sv ====
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // accept when empty or the held entry leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_q <= `EXEC_RESET_WORD;
        end else if (in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// ==== rtl/exec_pkg.sv ====
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        OP_ADDI,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_LW,
        OP_BEQ,
        OP_ILLEGAL
    } op_class_e;

    typedef struct packed {
        op_class_e op;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        word_t     pc;
        word_t     mem_data; // loaded word for lw
        reg_addr_t rd;
        logic      we;       // requested write enable
    } exec_req_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      we;       // gated write enable
        word_t     result;
        word_t     next_pc;
        logic      trap;
    } commit_t;

endpackage

// ==== rtl/exec_result.sv ====
`timescale 1ns/10ps

module exec_result (
    exec_bus_if.result_unit bus
);
    import exec_pkg::*;

    word_t alu_a;
    word_t alu_sum;
    word_t link_addr;

    // operand a by class
    always_comb begin
        case (bus.req.op)
            OP_AUIPC: alu_a = bus.req.pc;
            OP_LUI:   alu_a = '0;
            default:  alu_a = bus.req.rs1_data;
        endcase
    end

    assign alu_sum   = alu_a + bus.req.imm;
    assign link_addr = bus.req.pc + 32'd4; // return address for jal/jalr

    always_comb begin
        case (bus.req.op)
            OP_JAL,
            OP_JALR: bus.result = link_addr;
            OP_LW:   bus.result = bus.req.mem_data;
            default: bus.result = alu_sum;
        endcase
    end

endmodule

// ==== rtl/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  exec_pkg::opcode_t   in_opcode,
    input  logic [2:0]          in_funct3,
    input  exec_pkg::word_t     in_rs1_data,
    input  exec_pkg::word_t     in_rs2_data,
    input  exec_pkg::word_t     in_imm,
    input  exec_pkg::word_t     in_pc,
    input  exec_pkg::word_t     in_mem_data,
    input  exec_pkg::reg_addr_t in_rd,
    input  logic                in_reg_write_en,
    output logic                out_valid,
    input  logic                out_ready,
    output exec_pkg::reg_addr_t out_rd,
    output logic                out_we,
    output exec_pkg::word_t     out_result,
    output exec_pkg::word_t     out_next_pc,
    output logic                out_trap
);
    import exec_pkg::*;

    exec_req_t  dec_req;
    logic       cmt_valid;
    logic       cmt_ready;
    commit_t    cmt_data;
    commit_t    out_data;

    exec_bus_if bus ();

    exec_decode u_decode (
        .opcode       (in_opcode),
        .funct3       (in_funct3),
        .rs1_data     (in_rs1_data),
        .rs2_data     (in_rs2_data),
        .imm          (in_imm),
        .pc           (in_pc),
        .mem_data     (in_mem_data),
        .rd           (in_rd),
        .reg_write_en (in_reg_write_en),
        .req          (dec_req)
    );

    exec_pipe_stage #(.payload_t(exec_req_t)) u_req_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_req),
        .out_valid (bus.valid),
        .out_ready (bus.ready),
        .out_data  (bus.req)
    );

    // both units read the registered request in parallel
    exec_result  u_result  (.bus(bus.result_unit));
    exec_next_pc u_next_pc (.bus(bus.pc_unit));

    exec_commit u_commit (
        .bus       (bus.commit),
        .out_valid (cmt_valid),
        .out_ready (cmt_ready),
        .out_data  (cmt_data)
    );

    exec_pipe_stage #(.payload_t(commit_t)) u_out_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmt_valid),
        .in_ready  (cmt_ready),
        .in_data   (cmt_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    assign out_rd      = out_data.rd;
    assign out_we      = out_data.we;
    assign out_result  = out_data.result;
    assign out_next_pc = out_data.next_pc;
    assign out_trap    = out_data.trap;

endmodule
